/* Bender.yml */
package:
  name: tetris

sources:
  - source/tetris_pkg.sv
  - source/tick_gen.sv
  - source/start_countdown.sv
  - source/piece_source.sv
  - source/active_piece.sv
  - source/playfield.sv
  - source/game_ctrl.sv
  - source/tetris_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tetris_sva.sv
      - verif/tetris_tb.sv

/* source/active_piece.sv */
module active_piece (
  input  logic                      clk,
  input  logic                      rst,
  input  tetris_pkg::field_cmd_t    cmd,
  input  tetris_pkg::piece_kind_t   kind,
  input  tetris_pkg::board_t        board,
  output tetris_pkg::piece_status_t status,
  output tetris_pkg::board_t        placed
);
  import tetris_pkg::*;

  pos_t   pos;
  shape_t shape;
  shape_t spawn_shape;
  logic   active;
  logic   spawn_ok;
  logic   fall_ok;
  logic   left_ok;
  logic   right_ok;

  //////////////////////////////////////////////////
  // collision test, anything off the board is solid
  function automatic logic fits(int row, int col, shape_t s, board_t b);
    logic ok;
    int   r;
    int   c;
    ok = 1'b1;
    for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < 4; j++) begin
        r = row + k;
        c = col + j;
        if (s[k][j]) begin
          if (r < 0 || r >= board_rows || c < 0 || c >= board_cols) begin
            ok = 1'b0;
          end else if (b[r][c]) begin
            ok = 1'b0;
          end
        end
      end
    end
    return ok;
  endfunction

  function automatic board_t place(pos_t p, shape_t s);
    board_t b;
    int     r;
    int     c;
    b = '0;
    for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < 4; j++) begin
        r = int'(p.row) + k;
        c = int'(p.col) + j;
        if (s[k][j] && r < board_rows && c < board_cols) begin
          b[r][c] = 1'b1;
        end
      end
    end
    return b;
  endfunction

  assign spawn_shape = shape_lut(kind);
  assign spawn_ok    = fits(0, spawn_col, spawn_shape, board);
  assign fall_ok     = fits(int'(pos.row) + 1, int'(pos.col), shape, board);
  assign left_ok     = fits(int'(pos.row), int'(pos.col) - 1, shape, board);
  assign right_ok    = fits(int'(pos.row), int'(pos.col) + 1, shape, board);

  assign placed = active ? place(pos, shape) : '0;

  //////////////////////////////////////////////////
  // piece state and status flags
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      active <= 1'b0;
      status <= '0;
    end else begin
      status <= '0; // flags are single pulses
      if (cmd.spawn) begin
        active               <= spawn_ok; // blocked spawn never shows
        status.spawn_blocked <= !spawn_ok;
      end else if (cmd.fall && active && !fall_ok) begin
        status.landed <= 1'b1;
      end else if (cmd.lock || cmd.wipe) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.spawn) begin
      shape   <= spawn_shape;
      pos.row <= '0;
      pos.col <= 4'(spawn_col);
    end else if (active) begin
      if (cmd.fall && fall_ok) begin
        pos.row <= pos.row + 5'd1;
      end else if (cmd.shift_left && left_ok) begin
        pos.col <= pos.col - 4'd1;
      end else if (cmd.shift_right && right_ok) begin
        pos.col <= pos.col + 4'd1;
      end
    end
  end

endmodule

/* source/game_ctrl.sv */
module game_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      en,
  input  logic                      left,
  input  logic                      right,
  input  logic                      down,
  input  logic                      drop_tick,
  input  logic                      count_done,
  input  tetris_pkg::piece_status_t status,
  input  logic                      clear_done,
  input  logic                      top_filled,
  output tetris_pkg::field_cmd_t    cmd,
  output logic                      count_run,
  output logic                      drop_run,
  output logic                      game_over
);
  import tetris_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_ready,
    st_spawn,
    st_fall,
    st_lock,
    st_eval,
    st_over
  } state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////////////////////////
  // next state and command decode
  always_comb begin
    state_next = state;
    cmd        = '0;
    case (state)
      st_idle: begin
        if (en) state_next = st_ready;
      end
      st_ready: begin
        if (count_done) state_next = st_spawn;
      end
      st_spawn: begin
        cmd.spawn  = 1'b1;
        state_next = st_fall;
      end
      st_fall: begin
        if (status.spawn_blocked) begin
          state_next = st_over; // no room for the new piece
        end else if (status.landed) begin
          state_next = st_lock;
        end else if (drop_tick || down) begin
          cmd.fall = 1'b1;
        end else if (left) begin
          cmd.shift_left = 1'b1;
        end else if (right) begin
          cmd.shift_right = 1'b1;
        end
      end
      st_lock: begin
        cmd.lock   = 1'b1;
        state_next = st_eval;
      end
      st_eval: begin
        if (clear_done) state_next = top_filled ? st_over : st_spawn;
      end
      default: begin
        if (en) begin
          cmd.wipe   = 1'b1;
          state_next = st_idle;
        end
      end
    endcase
  end

  assign count_run = (state == st_ready);
  assign drop_run  = (state == st_fall);
  assign game_over = (state == st_over);

endmodule

/* source/piece_source.sv */
module piece_source (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    next,
  output tetris_pkg::piece_kind_t kind
);
  import tetris_pkg::*;

  logic [7:0]  lfsr;
  logic        feedback;
  piece_kind_t held;

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      lfsr <= lfsr_seed;
      held <= piece_a;
    end else if (next) begin
      lfsr <= {lfsr[6:0], feedback};
      held <= piece_kind_t'(lfsr[1:0]); // kind of the piece now in play
    end
  end

  // drawn kind goes straight out in the spawn cycle,
  // afterwards the kind in play is held
  assign kind = next ? piece_kind_t'(lfsr[1:0]) : held;

endmodule

/* source/playfield.sv */
module playfield (
  input  logic                   clk,
  input  logic                   rst,
  input  tetris_pkg::field_cmd_t cmd,
  input  tetris_pkg::board_t     placed,
  output tetris_pkg::board_t     board,
  output tetris_pkg::board_t     grid,
  output logic                   clear_done,
  output logic                   top_filled
);
  import tetris_pkg::*;

  logic       scan_busy;
  logic [4:0] scan_row;
  logic       row_full;
  board_t     collapsed;

  assign row_full = &board[scan_row];

  // drop everything at and above scan_row by one row
  always_comb begin
    collapsed = board;
    for (int r = board_rows - 1; r > 0; r--) begin
      if (r <= scan_row) begin
        collapsed[r] = board[r-1];
      end
    end
    collapsed[0] = '0;
  end

  //////////////////////////////////////////////////
  // lock merge and line-clear scan
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      board      <= '0;
      scan_busy  <= 1'b0;
      scan_row   <= '0;
      clear_done <= 1'b0;
    end else begin
      clear_done <= 1'b0;
      if (cmd.wipe) begin
        board     <= '0;
        scan_busy <= 1'b0;
      end else if (cmd.lock) begin
        board     <= board | placed;
        scan_busy <= 1'b1;
        scan_row  <= 5'(board_rows - 1); // start at the bottom
      end else if (scan_busy) begin
        if (row_full) begin
          board <= collapsed; // rescan same row next cycle
        end else if (scan_row == 5'd1) begin
          scan_busy  <= 1'b0;
          clear_done <= 1'b1;
        end else begin
          scan_row <= scan_row - 5'd1;
        end
      end
    end
  end

  assign grid       = board | placed;
  assign top_filled = |board[0]; // stack reached the spawn row

endmodule

/* source/start_countdown.sv */
module start_countdown (
  input  logic       clk,
  input  logic       rst,
  input  logic       run,
  input  logic       tick,
  output logic [7:0] seg,
  output logic       done
);
  import tetris_pkg::*;

  logic [1:0] count;
  logic       run_d;
  logic [7:0] digit;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      count <= '0;
      run_d <= 1'b0;
      done  <= 1'b0;
    end else begin
      run_d <= run;
      done  <= 1'b0;
      if (run && !run_d) begin
        count <= 2'(count_start); // fresh countdown
      end else if (run && tick && count != 2'd0) begin
        count <= count - 2'd1;
        if (count == 2'd1) begin
          done <= 1'b1;
        end
      end
    end
  end

  // segments are {dp, g, f, e, d, c, b, a}
  always_comb begin
    case (count)
      2'd1:    digit = 8'h06;
      2'd2:    digit = 8'h5b;
      2'd3:    digit = 8'h4f;
      default: digit = 8'h00; // finished, nothing to show
    endcase
  end

  assign seg = run ? digit : 8'h00;

endmodule

/* source/tetris_pkg.sv */
package tetris_pkg;

  //////////////////////////////////////////////////
  // board geometry and timing
  localparam int board_rows        = 21; // row 0 is the hidden spawn row
  localparam int board_cols        = 10;
  localparam int spawn_col         = 3;  // left edge of the mask at spawn
  localparam int count_start       = 3;
  localparam int count_tick_cycles = 16;
  localparam int drop_tick_cycles  = 256;
  localparam logic [7:0] lfsr_seed = 8'hb7;

  //////////////////////////////////////////////////
  // board and piece types
  typedef logic [board_cols-1:0] row_t; // bit c is column c
  typedef row_t [board_rows-1:0] board_t;

  typedef enum logic [1:0] {
    piece_a, // s-shape
    piece_b, // z-shape
    piece_c, // straight bar
    piece_d  // square
  } piece_kind_t;

  typedef logic [3:0][3:0] shape_t; // [mask row][mask column]

  typedef struct packed {
    logic [4:0] row;
    logic [3:0] col;
  } pos_t;

  typedef struct packed {
    logic spawn;
    logic fall;
    logic shift_left;
    logic shift_right;
    logic lock;
    logic wipe;
  } field_cmd_t;

  typedef struct packed {
    logic landed;
    logic spawn_blocked;
  } piece_status_t;

  function automatic shape_t shape_lut(piece_kind_t kind);
    shape_t s;
    s = '0;
    case (kind)
      piece_a: begin
        s[0] = 4'b0110;
        s[1] = 4'b0011;
      end
      piece_b: begin
        s[0] = 4'b0011;
        s[1] = 4'b0110;
      end
      piece_c: s[0] = 4'b1111;
      default: begin
        s[0] = 4'b0011;
        s[1] = 4'b0011;
      end
    endcase
    return s;
  endfunction

endpackage

/* source/tetris_top.sv */
module tetris_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    en,
  input  logic                    left,
  input  logic                    right,
  input  logic                    down,
  output tetris_pkg::board_t      grid,
  output logic [7:0]              count_seg,
  output tetris_pkg::piece_kind_t piece_kind,
  output logic                    game_over
);
  import tetris_pkg::*;

  field_cmd_t    cmd;
  piece_status_t status;
  board_t        board;
  board_t        placed;
  logic          count_run;
  logic          count_tick;
  logic          count_done;
  logic          drop_run;
  logic          drop_tick;
  logic          clear_done;
  logic          top_filled;

  game_ctrl ctrl0 (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .left       (left),
    .right      (right),
    .down       (down),
    .drop_tick  (drop_tick),
    .count_done (count_done),
    .status     (status),
    .clear_done (clear_done),
    .top_filled (top_filled),
    .cmd        (cmd),
    .count_run  (count_run),
    .drop_run   (drop_run),
    .game_over  (game_over)
  );

  //////////////////////////////////////////////////
  // countdown and gravity timing
  tick_gen #(.period(count_tick_cycles)) count_tick0 (
    .clk  (clk),
    .rst  (rst),
    .run  (count_run),
    .tick (count_tick)
  );

  tick_gen #(.period(drop_tick_cycles)) drop_tick0 (
    .clk  (clk),
    .rst  (rst),
    .run  (drop_run),
    .tick (drop_tick)
  );

  start_countdown countdown0 (
    .clk  (clk),
    .rst  (rst),
    .run  (count_run),
    .tick (count_tick),
    .seg  (count_seg),
    .done (count_done)
  );

  //////////////////////////////////////////////////
  // pieces and board
  piece_source source0 (
    .clk  (clk),
    .rst  (rst),
    .next (cmd.spawn),
    .kind (piece_kind)
  );

  active_piece piece0 (
    .clk    (clk),
    .rst    (rst),
    .cmd    (cmd),
    .kind   (piece_kind),
    .board  (board),
    .status (status),
    .placed (placed)
  );

  playfield field0 (
    .clk        (clk),
    .rst        (rst),
    .cmd        (cmd),
    .placed     (placed),
    .board      (board),
    .grid       (grid),
    .clear_done (clear_done),
    .top_filled (top_filled)
  );

endmodule

/* source/tick_gen.sv */
module tick_gen #(
  parameter int period = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic run,
  output logic tick
);
  localparam int width = $clog2(period);

  logic [width-1:0] count;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      count <= '0;
      tick  <= 1'b0;
    end else if (!run) begin
      count <= '0; // restart the period on every run
      tick  <= 1'b0;
    end else if (count == width'(period - 1)) begin
      count <= '0;
      tick  <= 1'b1;
    end else begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

/* verif/tetris_sva.sv */
module tetris_sva (
  input logic                   clk,
  input logic                   rst,
  input tetris_pkg::field_cmd_t cmd,
  input tetris_pkg::board_t     placed,
  input tetris_pkg::board_t     board,
  input logic                   clear_done
);
  timeunit 1ns;
  timeprecision 1ps;

  int   error_count = 0;
  logic field_idle; // from clear_done or wipe until the next lock

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      field_idle <= 1'b1;
    end else if (cmd.lock) begin
      field_idle <= 1'b0;
    end else if (clear_done || cmd.wipe) begin
      field_idle <= 1'b1;
    end
  end

  overlap_check: assert property (@(posedge clk) disable iff (rst) ~|(placed & board))
    else begin
      error_count++;
      $error("falling piece overlaps a locked cell");
    end

  // worst case is 20 rows plus a few rescans
  lock_clear_check: assert property (@(posedge clk) disable iff (rst)
    cmd.lock |-> ##[1:45] clear_done)
    else begin
      error_count++;
      $error("line-clear scan did not finish after a lock");
    end

  quiet_board_check: assert property (@(posedge clk) disable iff (rst)
    field_idle && !cmd.lock && !cmd.wipe |=> $stable(board))
    else begin
      error_count++;
      $error("locked board changed while the field was idle");
    end

endmodule

bind playfield tetris_sva sva0 (
  .clk        (clk),
  .rst        (rst),
  .cmd        (cmd),
  .placed     (placed),
  .board      (board),
  .clear_done (clear_done)
);

/* verif/tetris_tests.svh */
//////////////////////////////////////////////////
// stimulus helpers
task automatic pulse_en();
  @(posedge clk);
  en <= 1'b1;
  @(posedge clk);
  en <= 1'b0;
endtask

task automatic locate_piece(output int row, output int col);
  board_t piece;
  row   = -1;
  col   = board_cols;
  piece = grid & ~model;
  for (int r = 0; r < board_rows; r++) begin
    for (int c = 0; c < board_cols; c++) begin
      if (piece[r][c]) begin
        if (row < 0) row = r;
        if (c < col) col = c;
      end
    end
  end
  if (row < 0) begin
    abort_run("no falling piece is visible in grid");
  end else begin
    check_board("grid", model | put_shape(piece_kind, row, col), grid);
  end
endtask

task automatic move_piece(bit to_left, output int delta);
  int row0;
  int col0;
  int row1;
  int col1;
  delta = 0;
  for (int tries = 0; tries < 4; tries++) begin
    locate_piece(row0, col0);
    @(posedge clk);
    if (to_left) left <= 1'b1;
    else right <= 1'b1;
    @(posedge clk);
    left  <= 1'b0;
    right <= 1'b0;
    @(negedge clk);
    locate_piece(row1, col1);
    if (row1 == row0) begin
      delta = col1 - col0;
      return;
    end // gravity won the cycle, try again
  end
  abort_run("piece kept falling during a sideways move");
endtask

task automatic steer_to(int target);
  int row;
  int col;
  int delta;
  for (int n = 0; n < 12; n++) begin
    locate_piece(row, col);
    if (col == target) break;
    move_piece(col > target, delta);
    if (delta == 0) break; // blocked by the stack
  end
endtask

task automatic drop_piece(output bit over);
  int          row;
  int          col;
  int          land;
  int          n;
  piece_kind_t kind;
  bit          expect_over;
  board_t      next_spawn;
  locate_piece(row, col);
  kind = piece_kind;
  land = row;
  while (piece_fits(kind, land + 1, col, model)) land++;
  @(posedge clk);
  down <= 1'b1;
  n = 0;
  do begin
    @(negedge clk);
    locate_piece(row, col);
    n++;
  end while (row != land && n < 40);
  if (row != land) abort_run("piece did not fall to its landing row");
  @(posedge clk);
  down <= 1'b0;
  model = model | put_shape(kind, land, col);
  clear_full_rows();
  expect_over = |model[0];
  n = 0;
  do begin
    @(negedge clk);
    next_spawn = model | put_shape(piece_kind, 0, spawn_col);
    n++;
  end while (!game_over && (expect_over || grid !== next_spawn) && n < 200);
  if (game_over) begin
    check_board("grid", model, grid);
    if (!expect_over) check_flag("spawn fits", 1'b0, piece_fits(piece_kind, 0, spawn_col, model));
  end else begin
    check_flag("game_over", expect_over, game_over);
    check_board("grid", next_spawn, grid);
  end
  over = game_over;
endtask

//////////////////////////////////////////////////
// directed tests
task automatic test_reset_idle();
  for (int n = 0; n < 50; n++) begin
    @(negedge clk);
    check_board("grid", '0, grid);
    check_seg("count_seg", 8'h00, count_seg);
    check_flag("game_over", 1'b0, game_over);
  end
endtask

task automatic wait_seg_change(logic [7:0] from);
  int n;
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (count_seg === from && n < 64);
  if (count_seg === from) abort_run("countdown digit did not change");
endtask

task automatic test_countdown_spawn();
  logic [7:0] prev;
  int         n;
  pulse_en();
  prev = 8'h00;
  for (int d = count_start; d >= 1; d--) begin
    wait_seg_change(prev);
    check_seg("count_seg", seg_digit(d), count_seg);
    prev = count_seg;
  end
  wait_seg_change(prev);
  check_seg("count_seg", 8'h00, count_seg);
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (grid === '0 && n < 40);
  check_board("grid", put_shape(piece_kind, 0, spawn_col), grid);
endtask

task automatic test_side_walls();
  int row;
  int col;
  int delta;
  int n;
  n = 0;
  do begin
    move_piece(1'b1, delta);
    if (delta != 0) check_flag("left step of one column", 1'b1, delta == -1);
    n++;
  end while (delta != 0 && n < 12);
  locate_piece(row, col);
  check_flag("leftmost cell at column 0", 1'b1, col == 0);
  n = 0;
  do begin
    move_piece(1'b0, delta);
    if (delta != 0) check_flag("right step of one column", 1'b1, delta == 1);
    n++;
  end while (delta != 0 && n < 12);
  locate_piece(row, col);
  check_flag("rightmost cell at column 9", 1'b1,
             col + piece_width(piece_kind) - 1 == board_cols - 1);
endtask

task automatic test_first_drop();
  bit over;
  drop_piece(over);
  check_flag("game_over", 1'b0, over);
endtask

task automatic test_random_drops(output bit over);
  int target;
  over = 1'b0;
  for (int i = 0; i < 10 && !over; i++) begin
    target = int'($urandom % (board_cols + 1 - piece_width(piece_kind)));
    steer_to(target);
    drop_piece(over);
  end
endtask

task automatic test_game_over(input bit over);
  int n;
  n = 0;
  while (!over && n < 30) begin
    drop_piece(over); // straight down at spawn_col
    n++;
  end
  check_flag("game_over", 1'b1, game_over);
  pulse_en();
  @(negedge clk);
  check_flag("game_over", 1'b0, game_over);
  check_board("grid", '0, grid);
  check_seg("count_seg", 8'h00, count_seg);
  model = '0;
endtask

/* verif/tetris_tb.sv */
module tetris_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tetris_pkg::*;

  logic        clk;
  logic        rst;
  logic        en;
  logic        left;
  logic        right;
  logic        down;
  board_t      grid;
  logic [7:0]  count_seg;
  piece_kind_t piece_kind;
  logic        game_over;
  board_t      model; // locked cells the dut should hold

  tetris_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .left       (left),
    .right      (right),
    .down       (down),
    .grid       (grid),
    .count_seg  (count_seg),
    .piece_kind (piece_kind),
    .game_over  (game_over)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // error handling and compare tasks
  task automatic abort_run(string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_board(string name, board_t exp, board_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_seg(string name, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  //////////////////////////////////////////////////
  // reference model of pieces and board
  // one nibble per cell, {row, col} offset inside the mask
  function automatic logic [15:0] cell_table(piece_kind_t k);
    case (k)
      piece_a: return 16'h1245;
      piece_b: return 16'h0156;
      piece_c: return 16'h0123;
      default: return 16'h0145;
    endcase
  endfunction

  function automatic board_t put_shape(piece_kind_t k, int row, int col);
    board_t      b;
    logic [15:0] code;
    b    = '0;
    code = cell_table(k);
    for (int i = 0; i < 4; i++) begin
      b[row + int'(code[4*i+2 +: 2])][col + int'(code[4*i +: 2])] = 1'b1;
    end
    return b;
  endfunction

  function automatic bit piece_fits(piece_kind_t k, int row, int col, board_t b);
    logic [15:0] code;
    int          r;
    int          c;
    code = cell_table(k);
    for (int i = 0; i < 4; i++) begin
      r = row + int'(code[4*i+2 +: 2]);
      c = col + int'(code[4*i +: 2]);
      if (r < 0 || r >= board_rows || c < 0 || c >= board_cols) return 1'b0;
      if (b[r][c]) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic int piece_width(piece_kind_t k);
    logic [15:0] code;
    int          w;
    code = cell_table(k);
    w    = 0;
    for (int i = 0; i < 4; i++) begin
      if (int'(code[4*i +: 2]) + 1 > w) w = int'(code[4*i +: 2]) + 1;
    end
    return w;
  endfunction

  // segments dp g f e d c b a
  function automatic logic [7:0] seg_digit(int d);
    case (d)
      1:       return 8'b0000_0110;
      2:       return 8'b0101_1011;
      3:       return 8'b0100_1111;
      default: return 8'b0000_0000;
    endcase
  endfunction

  task automatic clear_full_rows();
    int r;
    r = board_rows - 1;
    while (r >= 1) begin
      if (&model[r]) begin
        for (int m = r; m >= 1; m--) model[m] = model[m-1];
        model[0] = '0; // same row is checked again
      end else begin
        r--;
      end
    end
  endtask

  `include "tetris_tests.svh"

  always @(negedge clk) begin
    if (dut0.field0.sva0.error_count != 0) abort_run("a playfield assertion reported an error");
  end

  initial begin
    bit over;
    rst   = 1'b1;
    en    = 1'b0;
    left  = 1'b0;
    right = 1'b0;
    down  = 1'b0;
    model = '0;
    over  = 1'b0;
    void'($urandom(32'h2be1));
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_reset_idle();
    test_countdown_spawn();
    test_side_walls();
    test_first_drop();
    test_random_drops(over);
    test_game_over(over);
    if (dut0.field0.sva0.error_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("a playfield assertion reported an error");
    end
  end

endmodule

/* verilog.f */
+incdir+verif
source/tetris_pkg.sv
source/tick_gen.sv
source/start_countdown.sv
source/piece_source.sv
source/active_piece.sv
source/playfield.sv
source/game_ctrl.sv
source/tetris_top.sv
verif/tetris_sva.sv
verif/tetris_tb.sv
